//--- Makefile
# Verilator build and run for the sprite engine testbench

SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= sprite_engine_tb
FILELIST  ?= sprite_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
FAIL_MSG  ?= Test failed

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	set -o pipefail; ./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/sprite_engine_tb.sv
`default_nettype none

module sprite_engine_tb
	import sprite_pkg::*;
();

	localparam int NUM_SPRITES  = 32;
	localparam int LINE_WIDTH   = 360;
	localparam int ADDR_WIDTH   = 21;
	localparam int IDLE_TIMEOUT = 5000;	// cycles, far above a full walk

	logic                  clk;
	logic                  reset;
	logic                  line_start;
	logic                  frame_start;
	logic                  pixel_strobe;
	logic                  desc_we;
	logic [7:0]            desc_addr;
	sprite_desc_t          desc_wdata;
	logic                  pal_we;
	logic [7:0]            pal_addr;
	pixel_t                pal_wdata;
	logic                  mem_strobe;
	logic [15:0]           mem_data;
	logic                  mem_req;
	logic [ADDR_WIDTH-1:0] mem_addr;
	pixel_t                pixel;
	logic                  busy;

	sprite_desc_t          descs [NUM_SPRITES];	// what the DUT is loaded with
	pixel_t                pal_model [256];
	pixel_t                expected [LINE_WIDTH];
	logic [ADDR_WIDTH-1:0] exp_addrs [$];
	logic [ADDR_WIDTH-1:0] req_log [$];	// every request seen, in order
	logic [31:0]           lfsr;
	int                    errors;
	int                    checks;

	sprite_engine #(
		.NUM_SPRITES(NUM_SPRITES), .LINE_WIDTH(LINE_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
	) dut0 (
		.clk(clk), .reset(reset), .line_start(line_start), .frame_start(frame_start),
		.pixel_strobe(pixel_strobe), .desc_we(desc_we), .desc_addr(desc_addr),
		.desc_wdata(desc_wdata), .pal_we(pal_we), .pal_addr(pal_addr), .pal_wdata(pal_wdata),
		.mem_strobe(mem_strobe), .mem_data(mem_data), .mem_req(mem_req), .mem_addr(mem_addr),
		.pixel(pixel), .busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// memory model
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;	// galois, right shifting
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);	// one step per bit
		end
	endtask

	// data word is a hash of its address
	function automatic logic [15:0] mem_word(input logic [ADDR_WIDTH-1:0] a);
		logic [31:0] prod;
		prod = 32'(a) * 32'h9e37;
		return prod[15:0] ^ a[15:0];
	endfunction

	initial
	begin : mem_responder
		logic [ADDR_WIDTH-1:0] addr;
		int                    delay;
		lfsr = 32'hb57044a3;
		mem_strobe = 1'b0;
		mem_data = '0;
		forever
		begin
			@(negedge clk);
			if (mem_req)
			begin
				addr = mem_addr;
				req_log.push_back(addr);
				take_bits(2, delay);	// 1 to 4 cycles
				repeat (delay + 1) @(posedge clk);
				mem_strobe <= 1'b1;
				mem_data <= mem_word(addr);
				@(posedge clk);
				mem_strobe <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// checks and report
	// ------------------------------------------------------------------------

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got == want)
		else
		begin
			$display("mismatch %s: got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < IDLE_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
		begin
			$display("timeout, busy still high after %0d cycles", IDLE_TIMEOUT);
			errors++;
			finish_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// register writes and video timing
	// ------------------------------------------------------------------------

	function automatic sprite_desc_t make_desc(input color_mode_t mode, input int pal,
		input bit flipx, input bit flipy, input int x, input int y, input int height,
		input int words, input int base);
		sprite_desc_t d;
		d = '0;
		d.mode = mode;
		d.pal = 4'(pal);
		d.flipx = flipx;
		d.flipy = flipy;
		d.x = 9'(x);
		d.y = 9'(y);
		d.height = 8'(height);
		d.words = 6'(words);
		d.base = 21'(base);
		return d;
	endfunction

	task automatic load_descs();
		for (int i = 0; i < NUM_SPRITES; i++)
		begin
			@(posedge clk);
			desc_we <= 1'b1;
			desc_addr <= 8'(i);
			desc_wdata <= descs[i];
		end
		@(posedge clk);
		desc_we <= 1'b0;
	endtask

	task automatic write_pal(input int a, input pixel_t value);
		@(posedge clk);
		pal_we <= 1'b1;
		pal_addr <= 8'(a);
		pal_wdata <= value;
		pal_model[a] = value;
		@(posedge clk);
		pal_we <= 1'b0;
	endtask

	// roughly half the entries come out transparent
	task automatic fill_palette();
		logic [7:0] a;
		for (int i = 0; i < 256; i++)
		begin
			a = 8'(i);
			pal_model[i].opaque = ^a;
			pal_model[i].color = a[5:0] ^ {a[7:6], a[7:6], a[7:6]};
			@(posedge clk);
			pal_we <= 1'b1;
			pal_addr <= a;
			pal_wdata <= pal_model[i];
		end
		@(posedge clk);
		pal_we <= 1'b0;
	endtask

	task automatic start_line(input logic frame);
		@(posedge clk);
		line_start <= 1'b1;
		frame_start <= frame;
		@(posedge clk);
		line_start <= 1'b0;
		frame_start <= 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// line model
	// ------------------------------------------------------------------------

	task automatic build_expected(input int line);
		sprite_desc_t          d;
		int                    ofs;
		int                    src;
		int                    ppw;
		int                    idx;
		int                    k;
		int                    sx;
		logic [ADDR_WIDTH-1:0] a;
		logic [15:0]           w16;
		pixel_t                px;
		for (int x = 0; x < LINE_WIDTH; x++)
			expected[x] = '0;
		exp_addrs.delete();
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			d = descs[s];
			if (d.mode == mode_off)
				continue;
			if (line < int'(d.y) || line >= int'(d.y) + int'(d.height))
				continue;	// not on this line
			ofs = line - int'(d.y);
			src = d.flipy ? int'(d.height) - 1 - ofs : ofs;
			ppw = d.mode == mode_4c ? 8 : d.mode == mode_16c ? 4 : 1;
			for (int w = 0; w < int'(d.words); w++)
			begin
				a = ADDR_WIDTH'(int'(d.base) + src * int'(d.words) + w);
				exp_addrs.push_back(a);
				w16 = mem_word(a);
				for (int p = 0; p < ppw; p++)
				begin
					if (d.mode == mode_4c)
					begin
						idx = int'(w16 >> (14 - 2 * p)) & 3;	// msb pixel first
						px = pal_model[{d.pal, 4'(idx)}];
					end
					else if (d.mode == mode_16c)
					begin
						idx = int'(w16 >> (12 - 4 * p)) & 15;
						px = pal_model[{d.pal, 4'(idx)}];
					end
					else
						px = '{opaque: w16[7], color: w16[5:0]};	// no palette
					k = w * ppw + p;
					sx = d.flipx ? int'(d.x) + int'(d.words) * ppw - 1 - k : int'(d.x) + k;
					if (px.opaque && sx < LINE_WIDTH)
						expected[sx] = px;	// later sprite wins
				end
			end
		end
	endtask

	task automatic scan_line();
		for (int x = 0; x < LINE_WIDTH; x++)
		begin
			@(posedge clk);
			pixel_strobe <= 1'b1;
			@(posedge clk);
			pixel_strobe <= 1'b0;
			@(negedge clk);	// pixel registered on the strobe edge
			check_value($sformatf("pixel[%0d]", x), {25'd0, pixel}, {25'd0, expected[x]});
			@(posedge clk);
		end
	endtask

	// render one line from descs, then scan it out during the next one
	task automatic run_line(input int line);
		int log_start;
		int n_new;
		wait_idle();
		if (line > 0)
		begin
			start_line(1'b1);	// count from line 0
			for (int i = 1; i < line; i++)
				start_line(1'b0);
			wait_idle();
		end
		load_descs();
		build_expected(line);
		log_start = req_log.size();
		start_line(line == 0);
		@(negedge clk);
		check_true(busy, "busy did not rise after line_start");
		wait_idle();
		for (int s = 0; s < NUM_SPRITES; s++)
			descs[s] = '0;
		load_descs();	// following line renders nothing
		start_line(1'b0);
		scan_line();
		n_new = req_log.size() - log_start;
		check_value("mem_req count", 32'(n_new), 32'(exp_addrs.size()));
		for (int i = 0; i < n_new && i < exp_addrs.size(); i++)
			check_value($sformatf("mem_addr[%0d]", i), 32'(req_log[log_start + i]),
				32'(exp_addrs[i]));
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	task automatic check_after_reset();
		check_true(!busy, "busy high after reset");
		check_true(!mem_req, "mem_req high after reset");
		check_true(!pixel.opaque, "pixel opaque after reset");
		repeat (LINE_WIDTH + 4) @(posedge clk);	// line buffer sweep
		fill_palette();
		load_descs();	// all off
		run_line(0);
	endtask

	task automatic single_16c_sprite();
		write_pal(8'h53, '{opaque: 1'b1, color: 6'h11});
		descs[3] = make_desc(mode_16c, 5, 0, 0, 40, 8, 6, 3, 'h1200);
		run_line(10);
	endtask

	task automatic mixed_modes();
		write_pal(8'h20, '{opaque: 1'b0, color: 6'h3f});	// hole in bank 2
		write_pal(8'h21, '{opaque: 1'b1, color: 6'h2a});
		descs[0] = make_desc(mode_4c, 2, 0, 0, 100, 10, 4, 2, 'h400);
		descs[1] = make_desc(mode_tc, 0, 0, 0, 200, 9, 3, 5, 'h800);
		descs[2] = make_desc(mode_16c, 9, 0, 0, 350, 10, 1, 4, 'h900);	// clipped at right
		run_line(10);
	endtask

	task automatic flipped_sprites();
		descs[5] = make_desc(mode_16c, 3, 1, 1, 60, 20, 10, 2, 'h2000);
		descs[6] = make_desc(mode_4c, 12, 1, 0, 150, 20, 5, 1, 'h3000);
		descs[8] = make_desc(mode_tc, 0, 0, 1, 250, 22, 4, 3, 'h3400);
		run_line(23);
	endtask

	task automatic overlap_and_skip();
		descs[1] = make_desc(mode_16c, 4, 0, 0, 80, 30, 4, 4, 'h100);
		descs[2] = make_desc(mode_off, 4, 0, 0, 80, 30, 4, 4, 'h180);	// inactive
		descs[7] = make_desc(mode_4c, 6, 0, 0, 84, 28, 8, 1, 'h500);	// on top
		descs[9] = make_desc(mode_16c, 4, 0, 0, 20, 50, 4, 2, 'h600);	// below the line
		descs[31] = make_desc(mode_tc, 0, 0, 0, 90, 31, 1, 2, 'h700);
		run_line(31);
	endtask

	task automatic clear_and_frame();
		descs[4] = make_desc(mode_16c, 7, 0, 0, 10, 0, 2, 2, 'h40);
		run_line(0);
		run_line(0);	// same half again, nothing rendered
		descs[4] = make_desc(mode_16c, 7, 0, 0, 10, 0, 2, 2, 'h40);
		run_line(3);	// sprite is above this line
		descs[4] = make_desc(mode_16c, 7, 0, 0, 10, 0, 2, 2, 'h40);
		run_line(0);	// frame_start brings line 0 back
	endtask

	initial
	begin
		reset = 1'b1;
		line_start = 1'b0;
		frame_start = 1'b0;
		pixel_strobe = 1'b0;
		desc_we = 1'b0;
		desc_addr = '0;
		desc_wdata = '0;
		pal_we = 1'b0;
		pal_addr = '0;
		pal_wdata = '0;
		errors = 0;
		checks = 0;
		for (int s = 0; s < NUM_SPRITES; s++)
			descs[s] = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_after_reset();
		single_16c_sprite();
		mixed_modes();
		flipped_sprites();
		overlap_and_skip();
		clear_and_frame();
		finish_run();
	end

endmodule

`default_nettype wire

//--- design/line_buffer.sv
`default_nettype none

module line_buffer
	import sprite_pkg::*;
#(
	parameter int LINE_WIDTH = 360
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           line_start,
	input  wire                           pixel_strobe,
	input  wire                           render_we,
	input  wire [$clog2(LINE_WIDTH)-1:0]  render_x,
	input  wire pixel_t                   render_pixel,
	output pixel_t                        pixel
);

	localparam int XW = $clog2(LINE_WIDTH);

	logic          sel;	// half being rendered, the other one scans out
	logic [XW-1:0] col;	// scanout column
	logic          sweep;	// clear after reset still running
	logic [XW-1:0] sweep_addr;
	pixel_t        rd_word [2];

	// ------------------------------------------------------------------------
	// half select and scanout
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sel <= 1'b0;
			col <= '0;
			pixel <= '0;	// transparent
		end
		else
		begin
			if (line_start)
			begin
				sel <= ~sel;	// swap halves
				col <= '0;
			end
			else if (pixel_strobe && col != XW'(LINE_WIDTH - 1))
				col <= col + 1'b1;	// holds on the last column
			if (pixel_strobe)
				pixel <= rd_word[~sel];
		end
	end

	// both halves zeroed one address per clock after reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sweep <= 1'b1;
			sweep_addr <= '0;
		end
		else if (sweep)
		begin
			sweep_addr <= sweep_addr + 1'b1;
			if (sweep_addr == XW'(LINE_WIDTH - 1))
				sweep <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// the two line rams
	// ------------------------------------------------------------------------

	for (genvar h = 0; h < 2; h++)
	begin : g_half
		pixel_t        ram [LINE_WIDTH];
		logic          we;
		logic [XW-1:0] wa;
		pixel_t        wd;

		always_comb
		begin
			if (sweep)
			begin
				we = 1'b1;
				wa = sweep_addr;
				wd = '0;
			end
			else if (sel == 1'(h))
			begin
				we = render_we;	// render side
				wa = render_x;
				wd = render_pixel;
			end
			else
			begin
				we = pixel_strobe;	// scanout side, clear on read
				wa = col;
				wd = '0;
			end
		end

		always_ff @(posedge clk)
		begin
			if (we)
				ram[wa] <= wd;
		end

		assign rd_word[h] = ram[col];	// old value read before the clear lands
	end

	// the fetcher drops off-screen columns before they get here
	a_render_x: assert property (@(posedge clk) disable iff (reset)
		render_we |-> int'(render_x) < LINE_WIDTH)
		else $error("render write at column %0d past LINE_WIDTH", render_x);

endmodule

`default_nettype wire

//--- design/palette_ram.sv
`default_nettype none

module palette_ram
	import sprite_pkg::*;
(
	input  wire         clk,
	input  wire         pal_we,
	input  wire [7:0]   pal_addr,	// {bank, index}
	input  wire pixel_t pal_wdata,
	input  wire [7:0]   rd_addr,
	output pixel_t      rd_data
);

	// 16 banks of 16 colours
	// an entry with opaque clear punches a hole in the sprite
	pixel_t ram [256];

	always_ff @(posedge clk)
	begin
		if (pal_we)
			ram[pal_addr] <= pal_wdata;
	end

	// registered lookup, one cycle behind rd_addr
	always_ff @(posedge clk)
	begin
		rd_data <= ram[rd_addr];
	end

endmodule

`default_nettype wire

//--- design/sprite_engine.sv
`default_nettype none

module sprite_engine
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 32,
	parameter int LINE_WIDTH  = 360,
	parameter int ADDR_WIDTH  = 21
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   line_start,
	input  wire                   frame_start,
	input  wire                   pixel_strobe,
	input  wire                   desc_we,
	input  wire [7:0]             desc_addr,
	input  wire sprite_desc_t     desc_wdata,
	input  wire                   pal_we,
	input  wire [7:0]             pal_addr,
	input  wire pixel_t           pal_wdata,
	input  wire                   mem_strobe,
	input  wire [15:0]            mem_data,
	output logic                  mem_req,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output pixel_t                pixel,
	output logic                  busy
);

	// fetcher side wires
	logic [$clog2(NUM_SPRITES)-1:0] desc_rd_addr;
	sprite_desc_t                   desc_rd;
	logic [7:0]                     pal_rd_addr;
	pixel_t                         pal_rd;
	logic                           render_we;
	logic [$clog2(LINE_WIDTH)-1:0]  render_x;
	pixel_t                         render_pixel;

	sprite_file #(.NUM_SPRITES(NUM_SPRITES)) sprite_file0 (
		.clk(clk), .desc_we(desc_we), .desc_addr(desc_addr), .desc_wdata(desc_wdata),
		.rd_addr(desc_rd_addr), .rd_data(desc_rd)
	);

	palette_ram palette_ram0 (
		.clk(clk), .pal_we(pal_we), .pal_addr(pal_addr), .pal_wdata(pal_wdata),
		.rd_addr(pal_rd_addr), .rd_data(pal_rd)
	);

	sprite_fetcher #(
		.NUM_SPRITES(NUM_SPRITES), .LINE_WIDTH(LINE_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
	) sprite_fetcher0 (
		.clk(clk), .reset(reset), .line_start(line_start), .frame_start(frame_start),
		.busy(busy), .desc_rd_addr(desc_rd_addr), .desc_rd(desc_rd),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_strobe(mem_strobe), .mem_data(mem_data),
		.pal_rd_addr(pal_rd_addr), .pal_rd(pal_rd),
		.render_we(render_we), .render_x(render_x), .render_pixel(render_pixel)
	);

	line_buffer #(.LINE_WIDTH(LINE_WIDTH)) line_buffer0 (
		.clk(clk), .reset(reset), .line_start(line_start), .pixel_strobe(pixel_strobe),
		.render_we(render_we), .render_x(render_x), .render_pixel(render_pixel),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

//--- design/sprite_fetcher.sv
`default_nettype none

module sprite_fetcher
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 32,
	parameter int LINE_WIDTH  = 360,
	parameter int ADDR_WIDTH  = 21
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            line_start,
	input  wire                            frame_start,
	output logic                           busy,
	output logic [$clog2(NUM_SPRITES)-1:0] desc_rd_addr,
	input  wire sprite_desc_t              desc_rd,
	output logic                           mem_req,
	output logic [ADDR_WIDTH-1:0]          mem_addr,
	input  wire                            mem_strobe,
	input  wire [15:0]                     mem_data,
	output logic [7:0]                     pal_rd_addr,
	input  wire pixel_t                    pal_rd,
	output logic                           render_we,
	output logic [$clog2(LINE_WIDTH)-1:0]  render_x,
	output pixel_t                         render_pixel
);

	localparam int SW = $clog2(NUM_SPRITES);
	localparam int XW = $clog2(LINE_WIDTH);

	fetch_state_t          state;
	logic [8:0]            line_cnt;
	logic [8:0]            next_line;
	logic [SW-1:0]         num;	// sprite being walked
	logic                  pending;	// request out, strobe not yet back
	color_mode_t           cur_mode;
	logic [3:0]            cur_pal;
	logic                  cur_flipx;
	logic [5:0]            cur_words;
	logic [ADDR_WIDTH-1:0] line_addr;	// first word of the source line
	logic [5:0]            word_idx;
	logic [15:0]           data_sr;	// current word, msb pixel on top
	logic [2:0]            pix_cnt;	// pixels left in the word minus one
	logic [9:0]            xpos;
	logic                  p_valid;	// palette delay slot
	logic [9:0]            p_x;
	logic                  p_tc;
	pixel_t                p_tc_pix;
	logic [8:0]            offset;
	logic                  on_line;
	logic [7:0]            src_line;
	logic [13:0]           line_ofs;
	logic [1:0]            ppw_shift;
	logic [9:0]            span;	// sprite width in pixels
	logic [9:0]            x_first;
	logic [3:0]            pix_idx;

	// ------------------------------------------------------------------------
	// descriptor decode, valid in st_check
	// ------------------------------------------------------------------------

	assign next_line = frame_start ? 9'd0 : line_cnt + 9'd1;
	assign offset = line_cnt - desc_rd.y;
	assign on_line = desc_rd.mode != mode_off && line_cnt >= desc_rd.y
		&& offset < {1'b0, desc_rd.height};
	assign src_line = desc_rd.flipy ? desc_rd.height - 8'd1 - offset[7:0] : offset[7:0];
	assign line_ofs = src_line * desc_rd.words;

	always_comb
	begin
		case (desc_rd.mode)
			mode_4c:  ppw_shift = 2'd3;	// 8 per word
			mode_16c: ppw_shift = 2'd2;	// 4 per word
			default:  ppw_shift = 2'd0;
		endcase
	end

	assign span = {4'd0, desc_rd.words} << ppw_shift;
	assign x_first = desc_rd.flipx ? {1'b0, desc_rd.x} + span - 10'd1 : {1'b0, desc_rd.x};

	// palette lookup straight off the shift register
	assign pix_idx = cur_mode == mode_4c ? {2'b00, data_sr[15:14]} : data_sr[15:12];
	assign pal_rd_addr = {cur_pal, pix_idx};
	assign desc_rd_addr = num;
	assign busy = state != st_idle || p_valid;

	// render side lines up with the palette output
	assign render_pixel = p_tc ? p_tc_pix : pal_rd;
	assign render_we = p_valid && render_pixel.opaque && p_x < 10'(LINE_WIDTH);
	assign render_x = p_x[XW-1:0];

	always_ff @(posedge clk)
	begin
		if (reset)
			line_cnt <= '1;	// first line_start lands on 0
		else if (line_start)
			line_cnt <= next_line;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pending <= 1'b0;
		else if (mem_req)
			pending <= 1'b1;
		else if (mem_strobe)
			pending <= 1'b0;
	end

	// ------------------------------------------------------------------------
	// walk fsm
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			num <= '0;
			mem_req <= 1'b0;
			p_valid <= 1'b0;
		end
		else
		begin
			mem_req <= 1'b0;	// strobe only
			p_valid <= 1'b0;
			if (line_start)
			begin
				num <= '0;	// aborts whatever is left of the last line
				state <= next_line < 9'(VISIBLE_LINES) ? st_read_desc : st_idle;
			end
			else
			case (state)
			st_read_desc:
				state <= st_check;
			st_check:
			begin
				cur_mode <= desc_rd.mode;
				cur_pal <= desc_rd.pal;
				cur_flipx <= desc_rd.flipx;
				cur_words <= desc_rd.words;
				line_addr <= ADDR_WIDTH'(desc_rd.base) + ADDR_WIDTH'(line_ofs);
				xpos <= x_first;
				word_idx <= '0;
				state <= on_line ? st_request : st_next_sprite;
			end
			st_request:
				if (!pending)	// a strobe from an aborted line may still be due
				begin
					mem_req <= 1'b1;
					mem_addr <= line_addr + ADDR_WIDTH'(word_idx);
					state <= st_wait_data;
				end
			st_wait_data:
				if (mem_strobe)
				begin
					data_sr <= mem_data;
					pix_cnt <= cur_mode == mode_4c ? 3'd7 : cur_mode == mode_16c ? 3'd3 : 3'd0;
					state <= st_emit;
				end
			st_emit:
			begin
				p_valid <= 1'b1;
				p_x <= xpos;
				p_tc <= cur_mode == mode_tc;
				p_tc_pix <= '{opaque: data_sr[7], color: data_sr[5:0]};	// true colour
				xpos <= cur_flipx ? xpos - 10'd1 : xpos + 10'd1;
				data_sr <= cur_mode == mode_4c ? data_sr << 2 : data_sr << 4;
				pix_cnt <= pix_cnt - 3'd1;
				if (pix_cnt == 3'd0)
				begin
					word_idx <= word_idx + 6'd1;
					state <= word_idx + 6'd1 == cur_words ? st_next_sprite : st_request;
				end
			end
			st_next_sprite:
			begin
				num <= num + 1'b1;
				state <= num == SW'(NUM_SPRITES - 1) ? st_idle : st_read_desc;
			end
			default:
				state <= st_idle;
			endcase
		end
	end

	// memory answers each request exactly once, so never two in flight
	a_one_request: assert property (@(posedge clk) disable iff (reset) mem_req |-> !pending)
		else $error("mem_req while a request is still outstanding");

endmodule

`default_nettype wire

//--- design/sprite_file.sv
`default_nettype none

module sprite_file
	import sprite_pkg::*;
#(
	parameter int NUM_SPRITES = 32
) (
	input  wire                            clk,
	input  wire                            desc_we,
	input  wire [7:0]                      desc_addr,	// from the cpu side
	input  wire sprite_desc_t              desc_wdata,
	input  wire [$clog2(NUM_SPRITES)-1:0]  rd_addr,
	output sprite_desc_t                   rd_data
);

	localparam int SW = $clog2(NUM_SPRITES);

	sprite_desc_t ram [NUM_SPRITES];

	always_ff @(posedge clk)
	begin
		if (desc_we)
			ram[desc_addr[SW-1:0]] <= desc_wdata;
		rd_data <= ram[rd_addr];	// fetcher sees it next cycle
	end

	// upper address bits are dropped above, an out of range write would alias
	a_desc_addr: assert property (@(posedge clk) desc_we |-> int'(desc_addr) < NUM_SPRITES)
		else $error("descriptor write to sprite %0d past NUM_SPRITES", desc_addr);

endmodule

`default_nettype wire

//--- design/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// ------------------------------------------------------------------------
	// video geometry
	// ------------------------------------------------------------------------

	localparam int VISIBLE_LINES = 288;	// lines at or past this are blanking

	// ------------------------------------------------------------------------
	// sprite descriptor
	// ------------------------------------------------------------------------

	typedef enum logic [1:0] {
		mode_off = 2'd0,	// descriptor inactive
		mode_4c  = 2'd1,	// 2 bits per pixel, 8 per word
		mode_16c = 2'd2,	// 4 bits per pixel, 4 per word
		mode_tc  = 2'd3	// one direct colour pixel per word
	} color_mode_t;

	// one 64 bit word per sprite, msb first
	typedef struct packed {
		color_mode_t mode;
		logic [3:0]  pal;	// palette bank
		logic        flipx;
		logic        flipy;
		logic [8:0]  x;	// left edge
		logic [8:0]  y;	// top line
		logic [7:0]  height;	// in lines
		logic [5:0]  words;	// words per sprite line
		logic [20:0] base;	// word address of sprite line 0
		logic [2:0]  spare;	// pads the word out to 64 bits
	} sprite_desc_t;

	// palette entry, line buffer cell and video output
	typedef struct packed {
		logic       opaque;
		logic [5:0] color;
	} pixel_t;

	typedef enum logic [3:0] {
		st_idle,
		st_read_desc,	// descriptor address out
		st_check,	// descriptor back, visibility test
		st_request,	// word request to memory
		st_wait_data,
		st_emit,	// one pixel per clock
		st_next_sprite
	} fetch_state_t;

endpackage

`default_nettype wire

//--- sprite_engine.f
design/sprite_pkg.sv
design/sprite_file.sv
design/palette_ram.sv
design/line_buffer.sv
design/sprite_fetcher.sv
design/sprite_engine.sv
bench/sprite_engine_tb.sv
